//--- core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and register index widths
`define XLEN 32
`define REG_ADDR_W 5
`define NUM_REGS 32

`define RESET_PC 32'h0000_0000
// all-zero word, decodes to no known opcode
`define NOP_INSN 32'h0000_0000
`define INSN_BYTES 32'd4
`define WE_FULL 4'b1111

`endif

//--- rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b000_0011,
    OP_STORE  = 7'b010_0011,
    OP_BRANCH = 7'b110_0011,
    OP_JALR   = 7'b110_0111,
    OP_JAL    = 7'b110_1111,
    OP_IMM    = 7'b001_0011,
    OP_REG    = 7'b011_0011,
    OP_LUI    = 7'b011_0111,
    OP_AUIPC  = 7'b001_0111,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_f3_e;

  // shared by reg-reg and reg-imm forms
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_f3_e;

  // funct7[5], picks sub and sra/srai
  localparam int alu_alt_bit = 30;

endpackage

//--- core_pipe_pkg.sv
`include "core_defines.svh"

package core_pipe_pkg;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] insn;
  } decode_stage_t;

  // rd is zero for instructions that write no register
  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       insn;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`REG_ADDR_W-1:0] rd;
  } execute_stage_t;

  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       insn;
    logic [`XLEN-1:0]       alu_out;
    logic [`XLEN-1:0]       store_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   reg_we;
    logic                   is_load;
    logic                   is_store;
    logic                   halt;
  } memory_stage_t;

  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       insn;
    logic [`XLEN-1:0]       result;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   reg_we;
    logic                   halt;
  } writeback_stage_t;

  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic [3:0]       we;
  } dmem_req_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] insn;
  } trace_t;

  // where an operand value comes from
  typedef enum logic [1:0] {
    BYP_RF  = 2'd0,
    BYP_MEM = 2'd1,
    BYP_WB  = 2'd2
  } bypass_e;

endpackage

//--- stage_reg.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module stage_reg
  import core_pipe_pkg::*;
#(
  parameter type payload_t = decode_stage_t
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // all-zero payload has valid low, so it is a bubble
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

//--- reg_file.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  logic                   we,
  input  logic [`REG_ADDR_W-1:0] rd,
  input  logic [`XLEN-1:0]       rd_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 is cleared by reset and never written afterwards
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- hazard_unit.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module hazard_unit
  import rv_isa_pkg::*, core_pipe_pkg::*;
(
  input  logic [`XLEN-1:0] d_insn,
  input  execute_stage_t   x_stage,
  input  memory_stage_t    m_stage,
  input  writeback_stage_t w_stage,
  input  logic [`XLEN-1:0] d_rf_rs1,
  input  logic [`XLEN-1:0] d_rf_rs2,
  output logic [`XLEN-1:0] d_rs1_val,
  output logic [`XLEN-1:0] d_rs2_val,
  output logic [`XLEN-1:0] x_rs1_val,
  output logic [`XLEN-1:0] x_rs2_val,
  output logic             load_use_stall
);

  // youngest producer wins, x0 is never forwarded
  function automatic bypass_e source(input logic [`REG_ADDR_W-1:0] rs,
                                     input logic m_we, input logic [`REG_ADDR_W-1:0] m_rd,
                                     input logic w_we, input logic [`REG_ADDR_W-1:0] w_rd);
    if (rs == '0) return BYP_RF;
    if (m_we && (m_rd == rs)) return BYP_MEM;
    if (w_we && (w_rd == rs)) return BYP_WB;
    return BYP_RF;
  endfunction

  function automatic logic [`XLEN-1:0] pick(input bypass_e sel, input logic [`XLEN-1:0] rf_val);
    case (sel)
      BYP_MEM: return m_stage.alu_out;
      BYP_WB:  return w_stage.result;
      default: return rf_val;
    endcase
  endfunction

  logic [`REG_ADDR_W-1:0] d_rs1, d_rs2, x_rs1, x_rs2;
  bypass_e                d_rs1_src, d_rs2_src, x_rs1_src, x_rs2_src;
  opcode_e                d_op, x_op;
  logic                   d_reads_rs1, d_reads_rs2;

  assign d_rs1 = d_insn[19:15];
  assign d_rs2 = d_insn[24:20];
  assign x_rs1 = x_stage.insn[19:15];
  assign x_rs2 = x_stage.insn[24:20];

  // decode only sees writeback, the register file write lands at the next edge
  assign d_rs1_src = source(d_rs1, 1'b0, '0, w_stage.reg_we, w_stage.rd);
  assign d_rs2_src = source(d_rs2, 1'b0, '0, w_stage.reg_we, w_stage.rd);
  assign x_rs1_src = source(x_rs1, m_stage.reg_we, m_stage.rd, w_stage.reg_we, w_stage.rd);
  assign x_rs2_src = source(x_rs2, m_stage.reg_we, m_stage.rd, w_stage.reg_we, w_stage.rd);

  assign d_rs1_val = pick(d_rs1_src, d_rf_rs1);
  assign d_rs2_val = pick(d_rs2_src, d_rf_rs2);
  assign x_rs1_val = pick(x_rs1_src, x_stage.rs1_data);
  assign x_rs2_val = pick(x_rs2_src, x_stage.rs2_data);

  assign d_op        = opcode_e'(d_insn[6:0]);
  assign x_op        = opcode_e'(x_stage.insn[6:0]);
  assign d_reads_rs1 = d_op inside {OP_REG, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH, OP_JALR};
  assign d_reads_rs2 = d_op inside {OP_REG, OP_STORE, OP_BRANCH};

  // load data only exists in memory, so a direct consumer waits one cycle
  assign load_use_stall = x_stage.valid && (x_op == OP_LOAD) && (x_stage.rd != '0) &&
                          ((d_reads_rs1 && (x_stage.rd == d_rs1)) ||
                           (d_reads_rs2 && (x_stage.rd == d_rs2)));

endmodule

//--- execute_unit.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module execute_unit
  import rv_isa_pkg::*, core_pipe_pkg::*;
(
  input  execute_stage_t   x_stage,
  input  logic [`XLEN-1:0] rs1_val,
  input  logic [`XLEN-1:0] rs2_val,
  output memory_stage_t    m_next,
  output logic             redirect,
  output logic [`XLEN-1:0] redirect_pc
);

  logic [`XLEN-1:0] insn;
  opcode_e          opcode;
  logic [2:0]       funct3;
  logic             alt;
  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [`XLEN-1:0] op_b, alu_res, sra_res, link, jalr_sum, result;
  logic             is_sub, cond, taken;

  assign insn   = x_stage.insn;
  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign alt    = insn[alu_alt_bit];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // sub only exists in the reg-reg form, srai reuses the same alt bit
  assign op_b    = (opcode == OP_REG) ? rs2_val : imm_i;
  assign is_sub  = (opcode == OP_REG) && alt;
  assign sra_res = $signed(rs1_val) >>> op_b[4:0];

  always_comb begin
    case (alu_f3_e'(funct3))
      F3_ADD:  alu_res = is_sub ? rs1_val - op_b : rs1_val + op_b;
      F3_SLL:  alu_res = rs1_val << op_b[4:0];
      F3_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
      F3_SLTU: alu_res = {{(`XLEN-1){1'b0}}, rs1_val < op_b};
      F3_XOR:  alu_res = rs1_val ^ op_b;
      F3_SR:   alu_res = alt ? sra_res : rs1_val >> op_b[4:0];
      F3_OR:   alu_res = rs1_val | op_b;
      F3_AND:  alu_res = rs1_val & op_b;
      default: alu_res = '0;
    endcase
  end

  always_comb begin
    case (branch_f3_e'(funct3))
      BR_EQ:   cond = rs1_val == rs2_val;
      BR_NE:   cond = rs1_val != rs2_val;
      BR_LT:   cond = $signed(rs1_val) < $signed(rs2_val);
      BR_GE:   cond = $signed(rs1_val) >= $signed(rs2_val);
      BR_LTU:  cond = rs1_val < rs2_val;
      BR_GEU:  cond = rs1_val >= rs2_val;
      default: cond = 1'b0;
    endcase
  end

  assign link     = x_stage.pc + `INSN_BYTES;
  assign jalr_sum = rs1_val + imm_i;

  // loads and stores leave their address in alu_out
  always_comb begin
    result      = alu_res;
    taken       = 1'b0;
    redirect_pc = x_stage.pc + imm_b;
    case (opcode)
      OP_LUI:    result = imm_u;
      OP_AUIPC:  result = x_stage.pc + imm_u;
      OP_LOAD:   result = jalr_sum;
      OP_STORE:  result = rs1_val + imm_s;
      OP_BRANCH: taken = cond;
      OP_JAL: begin
        result      = link;
        taken       = 1'b1;
        redirect_pc = x_stage.pc + imm_j;
      end
      OP_JALR: begin
        result      = link;
        taken       = 1'b1;
        redirect_pc = {jalr_sum[`XLEN-1:1], 1'b0};
      end
      default: ;
    endcase
  end

  assign redirect = x_stage.valid && taken;

  assign m_next = '{
    valid:      x_stage.valid,
    pc:         x_stage.pc,
    insn:       insn,
    alu_out:    result,
    store_data: rs2_val,
    rd:         x_stage.rd,
    reg_we:     x_stage.valid && (x_stage.rd != '0),
    is_load:    x_stage.valid && (opcode == OP_LOAD),
    is_store:   x_stage.valid && (opcode == OP_STORE),
    halt:       x_stage.valid && (opcode == OP_SYSTEM) && (insn[31:7] == '0)
  };

endmodule

//--- rv_core.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module rv_core
  import rv_isa_pkg::*, core_pipe_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  output dmem_req_t        dmem_req,
  input  logic [`XLEN-1:0] dmem_rdata,
  output logic             halt,
  output trace_t           trace
);

  logic [`XLEN-1:0] pc, redirect_pc;
  logic             redirect, load_use_stall, d_reg_we;
  logic [`XLEN-1:0] d_rf_rs1, d_rf_rs2, d_rs1_val, d_rs2_val, x_rs1_val, x_rs2_val;
  opcode_e          d_op;
  decode_stage_t    d_next, d_q;
  execute_stage_t   x_next, x_q;
  memory_stage_t    m_next, m_q;
  writeback_stage_t w_next, w_q;

  // fetch, a redirect from execute overrides the stall
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!load_use_stall) begin
      pc <= pc + `INSN_BYTES;
    end
  end

  assign imem_addr = pc;
  assign d_next    = '{valid: 1'b1, pc: pc, insn: imem_data};

  stage_reg #(.payload_t(decode_stage_t)) decode_reg (
    .clk(clk), .rst(rst), .hold(load_use_stall), .flush(redirect), .d(d_next), .q(d_q)
  );

  // decode, rd stays zero for instructions without a destination
  assign d_op     = opcode_e'(d_q.insn[6:0]);
  assign d_reg_we = d_op inside {OP_LOAD, OP_IMM, OP_REG, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR};

  reg_file rf (
    .clk(clk), .rst(rst), .rs1(d_q.insn[19:15]), .rs2(d_q.insn[24:20]),
    .rs1_data(d_rf_rs1), .rs2_data(d_rf_rs2),
    .we(w_q.reg_we), .rd(w_q.rd), .rd_data(w_q.result)
  );

  hazard_unit hazards (
    .d_insn(d_q.valid ? d_q.insn : `NOP_INSN), .x_stage(x_q), .m_stage(m_q), .w_stage(w_q),
    .d_rf_rs1(d_rf_rs1), .d_rf_rs2(d_rf_rs2), .d_rs1_val(d_rs1_val), .d_rs2_val(d_rs2_val),
    .x_rs1_val(x_rs1_val), .x_rs2_val(x_rs2_val), .load_use_stall(load_use_stall)
  );

  assign x_next = '{
    valid:    d_q.valid,
    pc:       d_q.pc,
    insn:     d_q.insn,
    rs1_data: d_rs1_val,
    rs2_data: d_rs2_val,
    rd:       d_reg_we ? d_q.insn[11:7] : '0
  };

  // a stall sends a bubble into execute while decode holds
  stage_reg #(.payload_t(execute_stage_t)) execute_reg (
    .clk(clk), .rst(rst), .hold(1'b0), .flush(redirect || load_use_stall),
    .d(x_next), .q(x_q)
  );

  execute_unit alu (
    .x_stage(x_q), .rs1_val(x_rs1_val), .rs2_val(x_rs2_val),
    .m_next(m_next), .redirect(redirect), .redirect_pc(redirect_pc)
  );

  stage_reg #(.payload_t(memory_stage_t)) memory_reg (
    .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0), .d(m_next), .q(m_q)
  );

  // memory stage, word accesses only
  assign dmem_req = '{
    addr:  m_q.alu_out,
    wdata: m_q.store_data,
    we:    m_q.is_store ? `WE_FULL : 4'b0000
  };

  assign w_next = '{
    valid:  m_q.valid,
    pc:     m_q.pc,
    insn:   m_q.insn,
    result: m_q.is_load ? dmem_rdata : m_q.alu_out,
    rd:     m_q.rd,
    reg_we: m_q.reg_we,
    halt:   m_q.halt
  };

  stage_reg #(.payload_t(writeback_stage_t)) writeback_reg (
    .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0), .d(w_next), .q(w_q)
  );

  assign halt  = w_q.halt;
  assign trace = '{valid: w_q.valid, pc: w_q.pc, insn: w_q.insn};

endmodule

//--- tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int half_period = 10
) (
  output logic clk
);

  // 20 ns period with the default half period
  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

endmodule

//--- core_tb_assert.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module core_tb_assert
  import core_pipe_pkg::*;
(
  input logic             clk,
  input logic             rst,
  input logic [`XLEN-1:0] imem_addr,
  input dmem_req_t        dmem_req,
  input logic             halt,
  input trace_t           trace
);

  int failures = 0;

  fetch_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else begin
      $error("fetch address %h is not word aligned", imem_addr);
      failures++;
    end

  // word stores only, always on a word address
  store_mask: assert property (@(posedge clk) disable iff (rst)
    dmem_req.we != 4'b0000 |-> dmem_req.we == `WE_FULL && dmem_req.addr[1:0] == 2'b00)
    else begin
      $error("store enable %b at address %h is not an aligned full word",
             dmem_req.we, dmem_req.addr);
      failures++;
    end

  // an ecall leaves writeback after one cycle
  halt_pulse: assert property (@(posedge clk) halt |-> trace.valid ##1 !halt)
    else begin
      $error("halt raised without a valid trace or held for more than one cycle");
      failures++;
    end

  quiet_after_reset: assert property (@(posedge clk) rst |=> !trace.valid)
    else begin
      $error("valid trace in the cycle after reset");
      failures++;
    end

endmodule

bind rv_core core_tb_assert checks (
  .clk(clk), .rst(rst), .imem_addr(imem_addr), .dmem_req(dmem_req), .halt(halt), .trace(trace)
);

//--- core_tb.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module core_tb
  import core_pipe_pkg::*;
;

  localparam int max_cycles = 400;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [31:0] nop = 32'h0000_0013;

  logic             clk, rst, halt;
  logic [`XLEN-1:0] imem_addr, imem_data, dmem_rdata;
  dmem_req_t        dmem_req;
  trace_t           trace;

  // image holds the program, mem is what the core sees
  logic [`XLEN-1:0] image [1024];
  logic [`XLEN-1:0] mem [1024];

  dmem_req_t   exp_stores[$], seen_stores[$];
  trace_t      seen_trace[$];
  logic [31:0] exp_pcs[$];
  logic [31:0] halt_pc, lcg_state;
  int          prog_len, slot, errors, npass, nfail;

  tb_clock clock_gen (.clk(clk));

  rv_core dut (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .halt(halt), .trace(trace)
  );

  assign imem_data  = mem[imem_addr[11:2]];
  assign dmem_rdata = mem[dmem_req.addr[11:2]];

  // reload during reset, otherwise commit stores
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= image[i];
      end
    end else if (dmem_req.we != 4'b0000) begin
      mem[dmem_req.addr[11:2]] <= dmem_req.wdata;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // RV32I integer results, b is rs2 or the sign-extended immediate
  function automatic logic [31:0] expect_alu(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] sra;
    sh  = b[4:0];
    sra = $signed(a) >>> sh;
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? sra : a >> sh;
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_word(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("error at %0t: %s got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_trace(input trace_t got, input trace_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t: %s got pc %h insn %h, expected pc %h insn %h",
               $time, what, got.pc, got.insn, exp.pc, exp.insn);
      errors++;
    end
  endtask

  task automatic check_store(input dmem_req_t got, input dmem_req_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t: %s got addr %h data %h we %b, expected addr %h data %h we %b",
               $time, what, got.addr, got.wdata, got.we, exp.addr, exp.wdata, exp.we);
      errors++;
    end
  endtask

  // fill pattern differs for every word address
  task automatic new_program();
    for (int i = 0; i < 1024; i++) begin
      image[i] = {~i[15:0], i[15:0]};
    end
    prog_len = 0;
    slot = 0;
    exp_stores.delete();
    seen_stores.delete();
    seen_trace.delete();
    exp_pcs.delete();
  endtask

  // runs marks an instruction that must retire, in program order
  task automatic emit(input logic [31:0] insn, input bit runs);
    if (runs) begin
      exp_pcs.push_back(32'(prog_len) * 32'd4);
    end
    image[prog_len] = insn;
    prog_len++;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    emit(u_type(hi[19:0], rd, 7'b0110111), 1'b1);
    emit(i_type(v[11:0], rd, 3'b000, rd, op_imm), 1'b1);
  endtask

  task automatic store_check(input logic [4:0] rs, input logic [31:0] val);
    logic [11:0] off;
    dmem_req_t   req;
    off = 12'h400 + 12'(slot * 4);
    emit(s_type(off, rs, 5'd0), 1'b1);
    req.addr  = {20'b0, off};
    req.wdata = val;
    req.we    = `WE_FULL;
    exp_stores.push_back(req);
    slot++;
  endtask

  // ecall, then a self loop that keeps fetch busy after halt
  task automatic finish_program();
    emit(32'h0000_0073, 1'b1);
    emit(j_type(21'd0, 5'd0), 1'b0);
  endtask

  task automatic run_program(input string name);
    int     cycles;
    bit     done;
    trace_t exp_t;
    @(negedge clk);
    rst = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    done = 1'b0;
    cycles = 0;
    while (!done && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
      if (trace.valid) seen_trace.push_back(trace);
      if (halt) begin
        halt_pc = trace.pc;
        done = 1'b1;
      end else if (dmem_req.we != 4'b0000) begin
        seen_stores.push_back(dmem_req);
      end
    end
    if (!done) begin
      $display("%s: timed out waiting for halt after %0d cycles", name, max_cycles);
      errors++;
    end
    if (seen_stores.size() != exp_stores.size()) begin
      $display("%s: saw %0d stores but the program makes %0d", name,
               seen_stores.size(), exp_stores.size());
      errors++;
    end
    for (int i = 0; i < seen_stores.size() && i < exp_stores.size(); i++) begin
      check_store(seen_stores[i], exp_stores[i], $sformatf("%s store %0d", name, i));
    end
    if (seen_trace.size() != exp_pcs.size()) begin
      $display("%s: %0d instructions retired but %0d were expected", name,
               seen_trace.size(), exp_pcs.size());
      errors++;
    end
    for (int i = 0; i < seen_trace.size() && i < exp_pcs.size(); i++) begin
      exp_t = '{valid: 1'b1, pc: exp_pcs[i], insn: image[exp_pcs[i][11:2]]};
      check_trace(seen_trace[i], exp_t, $sformatf("%s retire %0d", name, i));
    end
  endtask

  task automatic finish_test(input string name, input int start);
    if (errors == start) begin
      $display("%s: ok", name);
      npass++;
    end else begin
      $display("%s: %0d errors", name, errors - start);
      nfail++;
    end
  endtask

  task automatic alu_test();
    logic [31:0] a, b, r, pc;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    int          start;
    start = errors;
    new_program();
    a = next_rand();
    b = next_rand();
    load_const(5'd1, a);
    load_const(5'd2, b);
    // eight funct3 codes, then sub and sra
    for (int k = 0; k < 10; k++) begin
      f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
      alt = (k >= 8);
      emit(r_type(alt ? 7'b0100000 : 7'b0, 5'd2, 5'd1, f3, 5'd3), 1'b1);
      store_check(5'd3, expect_alu(f3, alt, a, b));
    end
    for (int k = 0; k < 9; k++) begin
      f3  = (k < 8) ? 3'(k) : 3'd5;
      alt = (k == 8);
      r   = next_rand();
      imm = r[11:0];
      if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'b0, r[4:0]};
      emit(i_type(imm, 5'd1, f3, 5'd3, op_imm), 1'b1);
      store_check(5'd3, expect_alu(f3, alt, a, {{20{imm[11]}}, imm}));
    end
    r = next_rand();
    emit(u_type(r[31:12], 5'd3, 7'b0110111), 1'b1);
    store_check(5'd3, {r[31:12], 12'b0});
    pc = 32'(prog_len) * 32'd4;
    emit(u_type(r[31:12], 5'd3, 7'b0010111), 1'b1);
    store_check(5'd3, pc + {r[31:12], 12'b0});
    finish_program();
    run_program("alu");
    finish_test("alu", start);
  endtask

  task automatic bypass_test();
    logic [31:0] a, v2, v3, v4, v5, v6;
    int          start;
    start = errors;
    new_program();
    a  = next_rand();
    v2 = a + a;
    v3 = v2 - a;
    v4 = a ^ v3;
    v5 = v2 | v4;
    v6 = v5 - a;
    load_const(5'd1, a);
    emit(r_type(7'b0, 5'd1, 5'd1, 3'd0, 5'd2), 1'b1);
    emit(r_type(7'b0100000, 5'd1, 5'd2, 3'd0, 5'd3), 1'b1);
    emit(r_type(7'b0, 5'd3, 5'd1, 3'd4, 5'd4), 1'b1);
    emit(nop, 1'b1);
    emit(r_type(7'b0, 5'd4, 5'd2, 3'd6, 5'd5), 1'b1);
    emit(nop, 1'b1);
    emit(nop, 1'b1);
    // x5 three instructions back
    emit(r_type(7'b0100000, 5'd1, 5'd5, 3'd0, 5'd6), 1'b1);
    store_check(5'd6, v6);
    store_check(5'd2, v2);
    store_check(5'd3, v3);
    store_check(5'd4, v4);
    store_check(5'd5, v5);
    finish_program();
    run_program("bypass");
    finish_test("bypass", start);
  endtask

  task automatic load_use_test();
    logic [31:0] a, b;
    int          start;
    start = errors;
    new_program();
    a = next_rand();
    b = next_rand();
    load_const(5'd1, a);
    load_const(5'd2, b);
    store_check(5'd1, a);
    emit(i_type(12'h400, 5'd0, 3'b010, 5'd3, 7'b0000011), 1'b1);
    emit(r_type(7'b0, 5'd2, 5'd3, 3'd0, 5'd4), 1'b1);
    store_check(5'd4, a + b);
    // loaded value as rs2 of sub and as store data
    emit(i_type(12'h400, 5'd0, 3'b010, 5'd5, 7'b0000011), 1'b1);
    emit(r_type(7'b0100000, 5'd5, 5'd2, 3'd0, 5'd6), 1'b1);
    store_check(5'd6, b - a);
    emit(i_type(12'h400, 5'd0, 3'b010, 5'd7, 7'b0000011), 1'b1);
    store_check(5'd7, a);
    finish_program();
    run_program("load_use");
    finish_test("load_use", start);
  endtask

  task automatic branch_pair(input logic [2:0] f3, input logic [4:0] ta, input logic [4:0] tb,
                             input logic [4:0] na, input logic [4:0] nb);
    emit(b_type(13'd8, tb, ta, f3), 1'b1);
    emit(s_type(12'h7f0, 5'd1, 5'd0), 1'b0);
    emit(b_type(13'd8, nb, na, f3), 1'b1);
    emit(nop, 1'b1);
  endtask

  task automatic control_flow_test();
    logic [31:0] link7, p;
    int          start;
    start = errors;
    new_program();
    // x1 = 5, x2 = -3, x3 = 5
    emit(i_type(12'd5, 5'd0, 3'd0, 5'd1, op_imm), 1'b1);
    emit(i_type(12'hffd, 5'd0, 3'd0, 5'd2, op_imm), 1'b1);
    emit(i_type(12'd5, 5'd0, 3'd0, 5'd3, op_imm), 1'b1);
    branch_pair(3'b000, 5'd1, 5'd3, 5'd1, 5'd2);
    branch_pair(3'b001, 5'd1, 5'd2, 5'd1, 5'd3);
    branch_pair(3'b100, 5'd2, 5'd1, 5'd1, 5'd2);
    branch_pair(3'b101, 5'd1, 5'd2, 5'd2, 5'd1);
    branch_pair(3'b110, 5'd1, 5'd2, 5'd2, 5'd1);
    branch_pair(3'b111, 5'd2, 5'd1, 5'd1, 5'd2);
    link7 = 32'(prog_len) * 32'd4 + 32'd4;
    emit(j_type(21'd12, 5'd7), 1'b1);
    emit(s_type(12'h7f0, 5'd1, 5'd0), 1'b0);
    emit(s_type(12'h7f0, 5'd1, 5'd0), 1'b0);
    // jalr target has bit zero set, the core must clear it
    p = 32'(prog_len) * 32'd4;
    emit(i_type(12'(p + 32'd17), 5'd0, 3'd0, 5'd5, op_imm), 1'b1);
    emit(i_type(12'd0, 5'd5, 3'd0, 5'd6, 7'b1100111), 1'b1);
    emit(s_type(12'h7f0, 5'd1, 5'd0), 1'b0);
    emit(s_type(12'h7f0, 5'd1, 5'd0), 1'b0);
    store_check(5'd7, link7);
    store_check(5'd6, p + 32'd8);
    finish_program();
    run_program("control_flow");
    finish_test("control_flow", start);
  endtask

  task automatic halt_test();
    logic [31:0] a, ecall_pc;
    int          start;
    start = errors;
    new_program();
    a = next_rand();
    load_const(5'd1, a);
    emit(i_type(12'd77, 5'd0, 3'd0, 5'd0, op_imm), 1'b1);
    emit(r_type(7'b0, 5'd1, 5'd1, 3'd0, 5'd0), 1'b1);
    emit(u_type(20'h12345, 5'd0, 7'b0110111), 1'b1);
    store_check(5'd0, 32'd0);
    ecall_pc = 32'(prog_len) * 32'd4;
    emit(32'h0000_0073, 1'b1);
    // younger store must not show up before halt
    emit(s_type(12'h7e0, 5'd1, 5'd0), 1'b0);
    emit(j_type(21'd0, 5'd0), 1'b0);
    run_program("halt");
    check_word(halt_pc, ecall_pc, "halt pc");
    finish_test("halt", start);
  endtask

  initial begin
    rst       = 1'b1;
    lcg_state = 32'h9b68;
    errors    = 0;
    npass     = 0;
    nfail     = 0;
    alu_test();
    bypass_test();
    load_use_test();
    control_flow_test();
    halt_test();
    $display("summary: %0d tests ok, %0d tests failing, %0d assertion failures",
             npass, nfail, dut.checks.failures);
    if (nfail == 0 && dut.checks.failures == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
rv_isa_pkg.sv
core_pipe_pkg.sv
stage_reg.sv
reg_file.sv
hazard_unit.sv
execute_unit.sv
rv_core.sv
tb_clock.sv
core_tb_assert.sv
core_tb.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= core_tb
FILELIST ?= verilog.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log
RUNFLAGS ?= +verilator+error+limit+1000

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) core_defines.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUNFLAGS) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
